//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := tb_ps2_keyboard_rx
RTL_TOP   := ps2_keyboard_rx
FILELIST  := ps2_keyboard_rx.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/ps2_ascii_map.sv
/*
  Scan code (set 2) to ASCII lookup, purely combinational.
  Covers letters, digits and a few control keys; all else gives '.'.
*/
`timescale 1ns/10ps

module ps2_ascii_map
  import ps2_kbd_pkg::*;
(
  input  scan_code_t lookup_code,
  input  logic       shift_on,
  output ascii_t     ascii
);

  ascii_t base;       // unshifted character
  logic   is_letter;

  // ------------------------------------------------------------
  // table
  // ------------------------------------------------------------
  always_comb
  begin
    base = ascii_unknown;
    case (lookup_code)
      // control keys, shift has no effect
      8'h66: base = 8'h08;   // backspace
      8'h0d: base = 8'h09;   // tab
      8'h5a: base = 8'h0d;   // enter
      8'h76: base = 8'h1b;   // escape
      8'h29: base = 8'h20;   // space
      // digit row, shifted symbols per US layout
      8'h45: base = shift_on ? ")" : "0";
      8'h16: base = shift_on ? "!" : "1";
      8'h1e: base = shift_on ? "@" : "2";
      8'h26: base = shift_on ? "#" : "3";
      8'h25: base = shift_on ? "$" : "4";
      8'h2e: base = shift_on ? "%" : "5";
      8'h36: base = shift_on ? "^" : "6";
      8'h3d: base = shift_on ? "&" : "7";
      8'h3e: base = shift_on ? "*" : "8";
      8'h46: base = shift_on ? "(" : "9";
      // letters, lower case here
      8'h1c: base = "a";
      8'h32: base = "b";
      8'h21: base = "c";
      8'h23: base = "d";
      8'h24: base = "e";
      8'h2b: base = "f";
      8'h34: base = "g";
      8'h33: base = "h";
      8'h43: base = "i";
      8'h3b: base = "j";
      8'h42: base = "k";
      8'h4b: base = "l";
      8'h3a: base = "m";
      8'h31: base = "n";
      8'h44: base = "o";
      8'h4d: base = "p";
      8'h15: base = "q";
      8'h2d: base = "r";
      8'h1b: base = "s";
      8'h2c: base = "t";
      8'h3c: base = "u";
      8'h2a: base = "v";
      8'h1d: base = "w";
      8'h22: base = "x";
      8'h35: base = "y";
      8'h1a: base = "z";
      default: base = ascii_unknown;
    endcase
  end

  // ------------------------------------------------------------
  // case fold
  // ------------------------------------------------------------
  // upper case sits 0x20 below lower case in ASCII
  assign is_letter = (base >= "a") && (base <= "z");
  assign ascii     = (is_letter && shift_on) ? ascii_t'(base - 8'h20) : base;

endmodule

//--- hw/ps2_frame_rx.sv
/*
  Receive-only PS/2 frame assembler. Keyboard lines are sampled by a
  single register stage, so the system clock must run well above the
  PS/2 clock. Parity and stop bits are captured but never checked.
*/
`timescale 1ns/10ps

module ps2_frame_rx
  import ps2_kbd_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic       frame_done,  // one-cycle pulse per frame
  output scan_code_t scan_code    // valid while frame_done is high
);

  logic            ps2_clk_s;       // sampled keyboard clock
  logic            ps2_data_s;      // sampled keyboard data
  rx_state_t       state;
  rx_state_t       state_next;
  frame_t          shift_q;
  bit_count_t      bit_count;
  watchdog_count_t watchdog_count;
  logic            watchdog_on;
  logic            watchdog_done;
  logic            falling_marker;

  // ------------------------------------------------------------
  // input sampling
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    ps2_clk_s  <= ps2_clk;
    ps2_data_s <= ps2_data;
  end

  // ------------------------------------------------------------
  // edge follower
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
      state <= rx_clk_h;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next = state;
    case (state)
      rx_clk_h:          if (!ps2_clk_s) state_next = rx_falling_marker;
      rx_falling_marker: state_next = rx_clk_l;   // single-cycle marker
      rx_clk_l:          if (ps2_clk_s) state_next = rx_rising_marker;
      rx_rising_marker:  state_next = rx_clk_h;
      default:           state_next = rx_clk_h;
    endcase
  end

  assign falling_marker = (state == rx_falling_marker);

  // keyboard drives data while its clock is high, so take it on the fall
  always_ff @(posedge clk)
  begin
    if (falling_marker)
      shift_q <= {ps2_data_s, shift_q[frame_bits-1:1]};  // lsb arrives first
  end

  // ------------------------------------------------------------
  // bit counter and watchdog
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset || frame_done)
      bit_count <= '0;
    else if (watchdog_done && (state == rx_clk_h) && ps2_clk_s)
      bit_count <= '0;                  // clock idled high mid-frame, drop it
    else if (falling_marker)
      bit_count <= bit_count + 1'b1;
  end

  // runs while the line sits at either level, restarts on every edge
  assign watchdog_on = (state == rx_clk_h) || (state == rx_clk_l);

  always_ff @(posedge clk)
  begin
    if (reset || !watchdog_on)
      watchdog_count <= '0;
    else if (!watchdog_done)
      watchdog_count <= watchdog_count + 1'b1;  // saturates at the limit
  end

  assign watchdog_done = (watchdog_count == watchdog_cycles);

  // count only sits at frame_bits for one cycle before it clears
  assign frame_done = (bit_count == bit_count_t'(frame_bits));
  assign scan_code  = shift_q[8:1];  // drop start, parity and stop

endmodule

//--- hw/ps2_kbd_pkg.sv
/*
  Shared types and constants for the PS/2 keyboard receiver.
  watchdog_cycles assumes a 50 MHz system clock (60 us idle timeout).
  Scan codes are set 2 and only the left ctrl key is tracked.
*/
package ps2_kbd_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------
  localparam int frame_bits     = 11;   // start, 8 data, parity, stop
  localparam int bit_count_bits = 4;
  localparam int watchdog_bits  = 12;

  typedef logic [7:0]                scan_code_t;      // one byte off the wire
  typedef logic [7:0]                ascii_t;
  typedef logic [frame_bits-1:0]     frame_t;          // raw shift register
  typedef logic [bit_count_bits-1:0] bit_count_t;
  typedef logic [watchdog_bits-1:0]  watchdog_count_t;

  // ------------------------------------------------------------
  // timing and scan codes
  // ------------------------------------------------------------
  localparam watchdog_count_t watchdog_cycles = 12'd3000;  // 60 us at 50 MHz

  localparam scan_code_t code_extend      = 8'he0;
  localparam scan_code_t code_release     = 8'hf0;
  localparam scan_code_t code_left_shift  = 8'h12;
  localparam scan_code_t code_right_shift = 8'h59;
  localparam scan_code_t code_left_ctrl   = 8'h14;

  localparam ascii_t ascii_unknown = 8'h2e;  // '.' for anything not in the table

  // ------------------------------------------------------------
  // state machines
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    rx_clk_h,
    rx_falling_marker,
    rx_clk_l,
    rx_rising_marker
  } rx_state_t;

  typedef enum logic {
    idle,
    ready
  } ready_state_t;

endpackage

//--- hw/ps2_key_tracker.sv
/*
  Prefix and modifier tracking plus the user-facing output registers.
  No buffering: a new report overwrites unread data and ready stays up.
  Prefix-only and zero frames clear the held flags but never report.
*/
`timescale 1ns/10ps

module ps2_key_tracker
  import ps2_kbd_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       frame_done,
  input  scan_code_t scan_code,
  input  ascii_t     ascii,
  input  logic       rx_read,
  output scan_code_t lookup_code,
  output logic       shift_on,
  output logic       rx_extended,
  output logic       rx_released,
  output logic       rx_shift_key_on,
  output logic       rx_ctrl_key_on,
  output scan_code_t rx_scan_code,
  output ascii_t     rx_ascii,
  output logic       rx_data_ready
);

  logic         is_extend;
  logic         is_release;
  logic         key_event;        // any non-prefix frame
  logic         report;           // key_event with a nonzero code
  logic         hold_extended;
  logic         hold_released;
  logic         left_shift;
  logic         right_shift;
  logic         ctrl_key;
  ready_state_t ready_state;
  ready_state_t ready_next;

  assign is_extend  = (scan_code == code_extend);
  assign is_release = (scan_code == code_release);
  assign key_event  = frame_done && !is_extend && !is_release;
  assign report     = key_event && (scan_code != 8'h00);

  // ------------------------------------------------------------
  // prefix and modifier state
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset || key_event)
    begin
      hold_extended <= 1'b0;   // prefixes apply to one key only
      hold_released <= 1'b0;
    end
    else if (frame_done)
    begin
      if (is_extend)  hold_extended <= 1'b1;
      if (is_release) hold_released <= 1'b1;
    end
  end

  // make sets, break (F0 prefix held) clears
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      left_shift  <= 1'b0;
      right_shift <= 1'b0;
      ctrl_key    <= 1'b0;
    end
    else if (frame_done)
    begin
      if (scan_code == code_left_shift)  left_shift  <= !hold_released;
      if (scan_code == code_right_shift) right_shift <= !hold_released;
      if (scan_code == code_left_ctrl)   ctrl_key    <= !hold_released;
    end
  end

  assign shift_on        = left_shift || right_shift;
  assign rx_shift_key_on = shift_on;
  assign rx_ctrl_key_on  = ctrl_key;
  assign lookup_code     = scan_code;  // lookup sees the live byte

  // ------------------------------------------------------------
  // output registers
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rx_extended  <= 1'b0;
      rx_released  <= 1'b0;
      rx_scan_code <= '0;
      rx_ascii     <= '0;
    end
    else if (report)
    begin
      rx_extended  <= hold_extended;
      rx_released  <= hold_released;
      rx_scan_code <= scan_code;
      rx_ascii     <= ascii;       // shift state as it was before this frame
    end
  end

  // data-ready handshake, level out and strobe in
  always_ff @(posedge clk)
  begin
    if (reset)
      ready_state <= idle;
    else
      ready_state <= ready_next;
  end

  always_comb
  begin
    ready_next = ready_state;
    case (ready_state)
      idle:    if (report) ready_next = ready;
      ready:   if (rx_read) ready_next = idle;
      default: ready_next = idle;
    endcase
  end

  assign rx_data_ready = (ready_state == ready);

endmodule

//--- hw/ps2_keyboard_rx.sv
/*
  PS/2 keyboard receiver top. Receive only, no host-to-keyboard path.
  rx_data_ready is a level; pulse rx_read for one clock to clear it.
*/
`timescale 1ns/10ps

module ps2_keyboard_rx
  import ps2_kbd_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  input  logic       rx_read,
  output logic       rx_extended,
  output logic       rx_released,
  output logic       rx_shift_key_on,
  output logic       rx_ctrl_key_on,
  output scan_code_t rx_scan_code,
  output ascii_t     rx_ascii,
  output logic       rx_data_ready
);

  logic       frame_done;
  scan_code_t scan_code;
  scan_code_t lookup_code;
  logic       shift_on;
  ascii_t     ascii;

  // serial side, bits to bytes
  ps2_frame_rx ps2_frame_rx_inst (
    .clk        (clk),
    .reset      (reset),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .frame_done (frame_done),
    .scan_code  (scan_code)
  );

  ps2_key_tracker ps2_key_tracker_inst (
    .clk             (clk),
    .reset           (reset),
    .frame_done      (frame_done),
    .scan_code       (scan_code),
    .ascii           (ascii),
    .rx_read         (rx_read),
    .lookup_code     (lookup_code),
    .shift_on        (shift_on),
    .rx_extended     (rx_extended),
    .rx_released     (rx_released),
    .rx_shift_key_on (rx_shift_key_on),
    .rx_ctrl_key_on  (rx_ctrl_key_on),
    .rx_scan_code    (rx_scan_code),
    .rx_ascii        (rx_ascii),
    .rx_data_ready   (rx_data_ready)
  );

  ps2_ascii_map ps2_ascii_map_inst (
    .lookup_code (lookup_code),
    .shift_on    (shift_on),
    .ascii       (ascii)          // same-cycle answer
  );

endmodule

//--- ps2_keyboard_rx.f
+incdir+verification
hw/ps2_kbd_pkg.sv
hw/ps2_frame_rx.sv
hw/ps2_key_tracker.sv
hw/ps2_ascii_map.sv
hw/ps2_keyboard_rx.sv
verification/tb_ps2_keyboard_rx.sv

//--- verification/ps2_key_vectors.svh
/*
  Key report table for the PS/2 receiver testbench, included in the tb module.
  Rows run in order, so modifier state carries from one row into the next.
*/
`ifndef PS2_KEY_VECTORS_SVH
`define PS2_KEY_VECTORS_SVH

// columns: count, byte 0..2, partial frame first, pulse rx_read,
//          then expected scan, ascii, extended, released, shift, ctrl
typedef struct packed {
  logic [1:0] count;     // bytes to send, 1 to 3
  logic [7:0] b0;
  logic [7:0] b1;
  logic [7:0] b2;
  logic       partial;   // 4 stray bits, then idle past the watchdog
  logic       read;
  logic [7:0] scan;
  logic [7:0] ascii;
  logic       ext;
  logic       rel;
  logic       shift;
  logic       ctrl;
} key_vector_t;

localparam int num_rows = 14;

localparam key_vector_t key_vectors [num_rows] = '{
  '{2'd1, 8'h1c, 8'h00, 8'h00, 1'b0, 1'b1, 8'h1c, "a",   1'b0, 1'b0, 1'b0, 1'b0},
  '{2'd1, 8'h12, 8'h00, 8'h00, 1'b0, 1'b1, 8'h12, 8'h2e, 1'b0, 1'b0, 1'b1, 1'b0},
  '{2'd1, 8'h1c, 8'h00, 8'h00, 1'b0, 1'b1, 8'h1c, "A",   1'b0, 1'b0, 1'b1, 1'b0},
  '{2'd1, 8'h16, 8'h00, 8'h00, 1'b0, 1'b1, 8'h16, "!",   1'b0, 1'b0, 1'b1, 1'b0},
  '{2'd2, 8'hf0, 8'h12, 8'h00, 1'b0, 1'b1, 8'h12, 8'h2e, 1'b0, 1'b1, 1'b0, 1'b0},
  '{2'd1, 8'h1c, 8'h00, 8'h00, 1'b0, 1'b1, 8'h1c, "a",   1'b0, 1'b0, 1'b0, 1'b0},
  '{2'd2, 8'he0, 8'h75, 8'h00, 1'b0, 1'b1, 8'h75, 8'h2e, 1'b1, 1'b0, 1'b0, 1'b0},
  '{2'd3, 8'he0, 8'hf0, 8'h75, 1'b0, 1'b1, 8'h75, 8'h2e, 1'b1, 1'b1, 1'b0, 1'b0},
  '{2'd1, 8'h14, 8'h00, 8'h00, 1'b0, 1'b1, 8'h14, 8'h2e, 1'b0, 1'b0, 1'b0, 1'b1},
  '{2'd2, 8'hf0, 8'h14, 8'h00, 1'b0, 1'b1, 8'h14, 8'h2e, 1'b0, 1'b1, 1'b0, 1'b0},
  '{2'd1, 8'h5a, 8'h00, 8'h00, 1'b0, 1'b1, 8'h5a, 8'h0d, 1'b0, 1'b0, 1'b0, 1'b0},
  '{2'd1, 8'h45, 8'h00, 8'h00, 1'b1, 1'b1, 8'h45, "0",   1'b0, 1'b0, 1'b0, 1'b0},
  '{2'd1, 8'h32, 8'h00, 8'h00, 1'b0, 1'b0, 8'h32, "b",   1'b0, 1'b0, 1'b0, 1'b0},
  '{2'd1, 8'h21, 8'h00, 8'h00, 1'b0, 1'b1, 8'h21, "c",   1'b0, 1'b0, 1'b0, 1'b0}
};

`endif

//--- verification/tb_ps2_keyboard_rx.sv
/*
  Testbench for the PS/2 keyboard receiver. Keyboard clock runs at 80
  system clocks per bit. Random gaps between frames use a fixed seed.
*/
`timescale 1ns/10ps

module tb_ps2_keyboard_rx
  import ps2_kbd_pkg::*;
;

  `include "ps2_key_vectors.svh"

  localparam int half_bit       = 40;     // keyboard clock half period in system cycles
  localparam int ready_wait_max = 400;
  localparam int timeout_cycles = num_rows * 3 * 900 + int'(watchdog_cycles) + 2000;

  logic       clk;
  logic       reset;
  logic       ps2_clk;
  logic       ps2_data;
  logic       rx_read;
  logic       rx_extended;
  logic       rx_released;
  logic       rx_shift_key_on;
  logic       rx_ctrl_key_on;
  scan_code_t rx_scan_code;
  ascii_t     rx_ascii;
  logic       rx_data_ready;

  int error_count  = 0;
  int rows_passed  = 0;
  int rows_failed  = 0;
  int cycle_count  = 0;

  ps2_keyboard_rx ps2_keyboard_rx_inst (
    .clk             (clk),
    .reset           (reset),
    .ps2_clk         (ps2_clk),
    .ps2_data        (ps2_data),
    .rx_read         (rx_read),
    .rx_extended     (rx_extended),
    .rx_released     (rx_released),
    .rx_shift_key_on (rx_shift_key_on),
    .rx_ctrl_key_on  (rx_ctrl_key_on),
    .rx_scan_code    (rx_scan_code),
    .rx_ascii        (rx_ascii),
    .rx_data_ready   (rx_data_ready)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;   // 50 MHz

  // watchdog on the whole run
  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= timeout_cycles)
    begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic check_value(input string field, input logic [7:0] got,
                             input logic [7:0] expected);
    if (got !== expected)
    begin
      $display("[FAIL] %0t %s: got %02h, expected %02h", $time, field, got, expected);
      error_count++;
    end
  endtask

  // start, 8 data lsb first, odd parity, stop; nbits < 11 cuts the frame short
  task automatic send_frame(input logic [7:0] code, input int nbits);
    logic [10:0] frame;
    frame = {1'b1, ~^code, code, 1'b0};
    for (int i = 0; i < nbits; i++)
    begin
      ps2_data = frame[i];          // data moves while clock is high
      wait_cycles(half_bit / 2);
      ps2_clk = 1'b0;
      wait_cycles(half_bit);
      ps2_clk = 1'b1;
      wait_cycles(half_bit / 2);
    end
    ps2_data = 1'b1;
  endtask

  task automatic wait_ready(output logic seen);
    int n;
    n = 0;
    while (!rx_data_ready && n < ready_wait_max)
    begin
      @(negedge clk);
      n++;
    end
    seen = rx_data_ready;
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial
  begin
    key_vector_t v;
    logic [7:0]  row_bytes [3];
    int          errors_before;
    int          gap;
    logic        was_ready;
    logic        got_ready;
    logic        prev_read;

    void'($urandom(32'h2e80));   // one seed for the whole run
    reset      = 1'b1;
    ps2_clk    = 1'b1;                 // lines idle high
    ps2_data   = 1'b1;
    rx_read    = 1'b0;
    prev_read  = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // values straight out of reset
    errors_before = error_count;
    check_value("rx_data_ready", 8'(rx_data_ready), 8'h00);
    check_value("rx_extended", 8'(rx_extended), 8'h00);
    check_value("rx_released", 8'(rx_released), 8'h00);
    check_value("rx_shift_key_on", 8'(rx_shift_key_on), 8'h00);
    check_value("rx_ctrl_key_on", 8'(rx_ctrl_key_on), 8'h00);
    check_value("rx_scan_code", rx_scan_code, 8'h00);
    check_value("rx_ascii", rx_ascii, 8'h00);
    if (error_count == errors_before)
      rows_passed++;
    else
      rows_failed++;
    $display("reset values %s", (error_count == errors_before) ? "ok" : "mismatch");

    for (int r = 0; r < num_rows; r++)
    begin
      v             = key_vectors[r];
      row_bytes[0]  = v.b0;
      row_bytes[1]  = v.b1;
      row_bytes[2]  = v.b2;
      errors_before = error_count;
      was_ready     = rx_data_ready;
      if (!prev_read)
        check_value("rx_data_ready held", 8'(rx_data_ready), 8'h01);  // unread data stays
      if (v.partial)
      begin
        send_frame(8'h00, 4);
        wait_cycles(int'(watchdog_cycles) + 200);   // let the watchdog drop it
      end
      for (int b = 0; b < int'(v.count); b++)
      begin
        gap = int'($urandom % 201);
        wait_cycles(gap);
        send_frame(row_bytes[b], frame_bits);
        if (!was_ready && b < int'(v.count) - 1)
          check_value("rx_data_ready on prefix", 8'(rx_data_ready), 8'h00);
      end
      wait_ready(got_ready);
      if (!got_ready)
      begin
        $display("no data ready from DUT");
        error_count++;
      end
      check_value("rx_scan_code", rx_scan_code, v.scan);
      check_value("rx_ascii", rx_ascii, v.ascii);
      check_value("rx_extended", 8'(rx_extended), 8'(v.ext));
      check_value("rx_released", 8'(rx_released), 8'(v.rel));
      check_value("rx_shift_key_on", 8'(rx_shift_key_on), 8'(v.shift));
      check_value("rx_ctrl_key_on", 8'(rx_ctrl_key_on), 8'(v.ctrl));
      if (v.read)
      begin
        rx_read = 1'b1;             // one-clock strobe
        @(negedge clk);
        rx_read = 1'b0;
        check_value("rx_data_ready after read", 8'(rx_data_ready), 8'h00);
      end
      prev_read = v.read;
      if (error_count == errors_before)
        rows_passed++;
      else
        rows_failed++;
      $display("row %0d code %02h %s", r, v.scan,
               (error_count == errors_before) ? "ok" : "mismatch");
    end

    $display("tests passed %0d, failed %0d", rows_passed, rows_failed);
    if (error_count == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
